//--- hw/CpuPkg.sv
package CpuPkg;

	// Program counter width, counted in halfwords
	localparam int PcBits = 16;

	// Data memory halfword address width
	localparam int MemAddrBits = 10;

	// Instruction memory size in 32-bit words
	localparam int ImemDepth = 256;

	// Datapath word
	typedef logic [31:0] Word;

	// Halfword address into instruction space
	typedef logic [PcBits-1:0] Pc;

	// Register number, sixteen registers
	typedef logic [3:0] RegNo;

	// Word address toward data memory
	typedef logic [MemAddrBits-2:0] MemWordAddr;

	// Instruction word index used by the load port
	typedef logic [7:0] ImemAddr;

	// Two-cycle memory access sequence
	typedef enum logic {AddrCompute, Access} MemState;

	// Opcodes, instruction bits 31..30
	localparam logic [1:0] OpSub = 2'b00;
	localparam logic [1:0] OpXan = 2'b01;
	localparam logic [1:0] OpMem = 2'b10;
	localparam logic [1:0] OpShift = 2'b11;

endpackage

//--- hw/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile (
	input logic CLK,
	input logic RST_X,
	// Read port 0
	input CpuPkg::RegNo ReadNo0,
	input logic ReadEn0,
	output CpuPkg::Word ReadData0,
	// Read port 1
	input CpuPkg::RegNo ReadNo1,
	input logic ReadEn1,
	output CpuPkg::Word ReadData1,
	// Single write port
	input CpuPkg::RegNo WriteNo,
	input logic WriteEn,
	input CpuPkg::Word WriteData
);

	// Sixteen general registers
	CpuPkg::Word regs [16];

	// Write lands at the clock edge
	always_ff @(posedge CLK) begin
		if (!RST_X) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (WriteEn) begin
			regs[WriteNo] <= WriteData;
		end
	end

	// Reads are combinational
	// Disabled port returns zero
	assign ReadData0 = ReadEn0 ? regs[ReadNo0] : '0;
	assign ReadData1 = ReadEn1 ? regs[ReadNo1] : '0;

	// No bypass, a same-cycle write is seen one cycle later

endmodule

//--- hw/Alu.sv
`timescale 1ns/10ps

module Alu (
	input CpuPkg::Word A,
	input CpuPkg::Word B,
	// Opcode field, and-not only for OpXan
	input logic [1:0] OpSelect,
	// Condition bits: zero, negative, positive
	input logic [2:0] CondSelect,
	output CpuPkg::Word Result,
	output logic CondMet
);

	logic isZero;
	logic isNegative;
	logic isPositive;

	// Memory ops also subtract here
	always_comb begin
		if (OpSelect == CpuPkg::OpXan) begin
			Result = A & ~B;
		end else begin
			Result = A - B;
		end
	end

	// Result properties
	assign isZero = (Result == '0);
	assign isNegative = Result[31];
	// Strictly above zero
	assign isPositive = !isNegative && !isZero;

	// Any selected property is enough
	assign CondMet = (CondSelect[0] && isZero)
		|| (CondSelect[1] && isNegative)
		|| (CondSelect[2] && isPositive);

	// Empty condition field never branches

endmodule

//--- hw/Shifter.sv
`timescale 1ns/10ps

module Shifter (
	input CpuPkg::Word Value,
	// Bit 4 direction, bits 3..0 amount
	input logic [4:0] Args,
	output CpuPkg::Word Result
);

	logic [3:0] amount;
	logic toRight;

	// Unpack the operand B field
	assign amount = Args[3:0];
	assign toRight = Args[4];

	// Logical shift, zeros fill in from either side
	always_comb begin
		if (toRight) begin
			Result = Value >> amount;
		end else begin
			Result = Value << amount;
		end
	end

	// Amount tops out at 15

endmodule

//--- hw/ComputeStage.sv
`timescale 1ns/10ps

module ComputeStage (
	input logic CLK,
	input logic RST_X,
	// From fetch
	input CpuPkg::Word Instruction,
	input logic Valid,
	input CpuPkg::Pc InstrPc,
	// Back to fetch
	output logic StallRequest,
	output logic BranchRequest,
	output CpuPkg::Pc BranchTarget,
	// Data memory port
	output logic MemEn,
	output CpuPkg::MemWordAddr MemAddr,
	input CpuPkg::Word MemRdata,
	output logic MemWen,
	output CpuPkg::Word MemWdata
);

	// Instruction fields
	logic [1:0] opcode;
	logic jumpFlag;
	logic [3:0] fieldA;
	logic [4:0] fieldB;
	CpuPkg::RegNo fieldD;
	logic [2:0] cond;
	logic [11:0] offset;
	logic isMem;
	logic isShift;
	logic isBranchOp;

	// Memory sequence state and its captured operands
	CpuPkg::MemState memState;
	CpuPkg::MemWordAddr memAddrReg;
	CpuPkg::RegNo memRegNo;
	logic memWrite;
	logic inAccess;
	logic exec;
	logic startMem;

	// Register file hookup
	CpuPkg::RegNo rdNo0;
	logic rdEn0;
	CpuPkg::Word rdData0;
	CpuPkg::RegNo rdNo1;
	logic rdEn1;
	CpuPkg::Word rdData1;
	CpuPkg::RegNo wrNo;
	logic wrEn;
	CpuPkg::Word wrData;

	// Datapath
	CpuPkg::Word aluA;
	CpuPkg::Word aluB;
	CpuPkg::Word aluResult;
	logic condMet;
	CpuPkg::Word shiftResult;

	// Decode
	assign opcode = Instruction[31:30];
	// Jump flag doubles as write flag for memory ops
	assign jumpFlag = Instruction[29];
	assign fieldA = Instruction[28:25];
	assign fieldB = Instruction[24:20];
	assign fieldD = Instruction[19:16];
	assign cond = Instruction[14:12];
	assign offset = Instruction[11:0];
	assign isMem = (opcode == CpuPkg::OpMem);
	assign isShift = (opcode == CpuPkg::OpShift);
	assign isBranchOp = (opcode == CpuPkg::OpSub) || (opcode == CpuPkg::OpXan);

	RegisterFile regFile (
		.CLK(CLK),
		.RST_X(RST_X),
		.ReadNo0(rdNo0),
		.ReadEn0(rdEn0),
		.ReadData0(rdData0),
		.ReadNo1(rdNo1),
		.ReadEn1(rdEn1),
		.ReadData1(rdData1),
		.WriteNo(wrNo),
		.WriteEn(wrEn),
		.WriteData(wrData)
	);

	Alu alu (
		.A(aluA),
		.B(aluB),
		.OpSelect(opcode),
		.CondSelect(cond),
		.Result(aluResult),
		.CondMet(condMet)
	);

	// Shifts take operand A, constants included
	Shifter shifter (
		.Value(aluA),
		.Args(fieldB),
		.Result(shiftResult)
	);

	// Instruction executes only outside the access cycle
	assign inAccess = (memState == CpuPkg::Access);
	assign exec = Valid && !inAccess;
	assign startMem = exec && isMem;

	// Port 0: operand A, or the store source during access
	assign rdNo0 = inAccess ? memRegNo : fieldA;
	assign rdEn0 = inAccess ? memWrite : ((fieldA[3:2] != 2'b00) && !isMem);
	// Port 1: operand B register, unused by shifts
	assign rdNo1 = fieldB[3:0];
	assign rdEn1 = !fieldB[4] && !isShift;

	// Operand A, registers 4..15 or a constant
	always_comb begin
		if (isMem) begin
			// Signed offset, doubled
			aluA = {{27{fieldA[3]}}, fieldA, 1'b0};
		end else if (fieldA[3:2] != 2'b00) begin
			aluA = rdData0;
		end else begin
			case (fieldA[1:0])
				2'd0: aluA = '0;
				2'd1: aluA = '1;
				2'd2: aluA = 32'd1;
				default: aluA = 32'hFFFF_FFFC;
			endcase
		end
	end

	// Operand B, register or prioritized constant
	always_comb begin
		if (!fieldB[4]) begin
			aluB = rdData1;
		end else if (fieldB[0]) begin
			aluB = '1;
		end else if (fieldB[1]) begin
			aluB = 32'd1;
		end else if (fieldB[2]) begin
			// PC as byte address
			aluB = CpuPkg::Word'({InstrPc, 1'b0});
		end else if (fieldB[3]) begin
			aluB = 32'd32;
		end else begin
			aluB = '0;
		end
	end

	// Address cycle always hands over to the access cycle
	always_ff @(posedge CLK) begin
		if (!RST_X) begin
			memState <= CpuPkg::AddrCompute;
		end else if (startMem) begin
			memState <= CpuPkg::Access;
		end else begin
			memState <= CpuPkg::AddrCompute;
		end
	end

	// Capture address, register and direction
	always_ff @(posedge CLK) begin
		if (startMem) begin
			// Byte address down to word address
			memAddrReg <= aluResult[CpuPkg::MemAddrBits:2];
			memRegNo <= fieldD;
			memWrite <= jumpFlag;
		end
	end

	// Fetch freezes for the access cycle
	assign StallRequest = inAccess;
	assign MemEn = inAccess;
	assign MemWen = inAccess && memWrite;
	assign MemAddr = memAddrReg;
	assign MemWdata = rdData0;

	// Write-back: load data, shift or ALU result
	assign wrEn = inAccess ? !memWrite : (exec && !isMem);
	assign wrNo = inAccess ? memRegNo : fieldD;
	assign wrData = inAccess ? MemRdata : (isShift ? shiftResult : aluResult);

	// PC-relative branch, halfword offset
	assign BranchRequest = exec && isBranchOp && jumpFlag && condMet;
	assign BranchTarget = InstrPc + CpuPkg::Pc'($signed(offset));

endmodule

//--- hw/FetchStage.sv
`timescale 1ns/10ps

module FetchStage (
	input logic CLK,
	input logic RST_X,
	// Program load port
	input logic LoadEn,
	input CpuPkg::ImemAddr LoadAddr,
	input CpuPkg::Word LoadData,
	// Control from compute
	input logic StallRequest,
	input logic BranchRequest,
	input CpuPkg::Pc BranchTarget,
	// Fetched instruction
	output CpuPkg::Word Instruction,
	output logic Valid,
	output CpuPkg::Pc InstrPc
);

	// Instruction store
	CpuPkg::Word imem [CpuPkg::ImemDepth];

	CpuPkg::Pc pc;
	CpuPkg::ImemAddr fetchIndex;

	// Halfword PC to word index
	assign fetchIndex = CpuPkg::ImemAddr'(pc >> 1);

	// Loaded while the core is held in reset
	always_ff @(posedge CLK) begin
		if (LoadEn) begin
			imem[LoadAddr] <= LoadData;
		end
	end

	// PC and valid flag
	always_ff @(posedge CLK) begin
		if (!RST_X) begin
			pc <= '0;
			Valid <= 1'b0;
		end else if (BranchRequest) begin
			// Redirect and drop the word in flight
			pc <= BranchTarget;
			Valid <= 1'b0;
		end else if (!StallRequest) begin
			pc <= pc + CpuPkg::Pc'(2);
			Valid <= 1'b1;
		end
	end

	// Instruction register with its own PC
	// Held during a stall
	always_ff @(posedge CLK) begin
		if (!StallRequest) begin
			Instruction <= imem[fetchIndex];
			InstrPc <= pc;
		end
	end

endmodule

//--- hw/Processor.sv
`timescale 1ns/10ps

module Processor (
	input logic CLK,
	input logic RST_X,
	// Program load port
	input logic LoadEn,
	input CpuPkg::ImemAddr LoadAddr,
	input CpuPkg::Word LoadData,
	// Data memory port
	output logic MemEn,
	output CpuPkg::MemWordAddr MemAddr,
	input CpuPkg::Word MemRdata,
	output logic MemWen,
	output CpuPkg::Word MemWdata
);

	// Fetch to compute
	CpuPkg::Word instruction;
	logic valid;
	CpuPkg::Pc instrPc;

	// Compute back to fetch
	logic stallRequest;
	logic branchRequest;
	CpuPkg::Pc branchTarget;

	FetchStage fetch (
		.CLK(CLK),
		.RST_X(RST_X),
		.LoadEn(LoadEn),
		.LoadAddr(LoadAddr),
		.LoadData(LoadData),
		.StallRequest(stallRequest),
		.BranchRequest(branchRequest),
		.BranchTarget(branchTarget),
		.Instruction(instruction),
		.Valid(valid),
		.InstrPc(instrPc)
	);

	// Decode, execute, memory and write-back
	ComputeStage compute (
		.CLK(CLK),
		.RST_X(RST_X),
		.Instruction(instruction),
		.Valid(valid),
		.InstrPc(instrPc),
		.StallRequest(stallRequest),
		.BranchRequest(branchRequest),
		.BranchTarget(branchTarget),
		.MemEn(MemEn),
		.MemAddr(MemAddr),
		.MemRdata(MemRdata),
		.MemWen(MemWen),
		.MemWdata(MemWdata)
	);

endmodule

//--- tb/ProcessorTb.sv
`timescale 1ns/10ps

module ProcessorTb;

	logic CLK;
	logic RST_X;
	logic LoadEn;
	CpuPkg::ImemAddr LoadAddr;
	CpuPkg::Word LoadData;
	logic MemEn;
	CpuPkg::MemWordAddr MemAddr;
	CpuPkg::Word MemRdata;
	logic MemWen;
	CpuPkg::Word MemWdata;

	// Program image, data memory model and reference results
	CpuPkg::Word prog [CpuPkg::ImemDepth];
	CpuPkg::Word mem [512];
	CpuPkg::Word refMem [512];
	CpuPkg::MemWordAddr expAddr [1024];
	CpuPkg::Word expData [1024];
	// Cycle of each store counted from reset release
	int expCycle [1024];
	int progLen = 0;
	int expCount = 0;
	int storeCount = 0;
	int refSteps = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int cycleNo = 0;
	logic refDone = 1'b0;
	logic prevEn = 1'b0;
	logic [15:0] lfsr = 16'd78;

	Processor DUT (
		.CLK(CLK),
		.RST_X(RST_X),
		.LoadEn(LoadEn),
		.LoadAddr(LoadAddr),
		.LoadData(LoadData),
		.MemEn(MemEn),
		.MemAddr(MemAddr),
		.MemRdata(MemRdata),
		.MemWen(MemWen),
		.MemWdata(MemWdata)
	);

	always #5 CLK = ~CLK;

	// Combinational read with the write at the edge
	assign MemRdata = mem[MemAddr];
	always @(posedge CLK) begin
		if (MemEn && MemWen) begin
			mem[MemAddr] <= MemWdata;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 16'hB400;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	function automatic CpuPkg::Word enc(input logic [1:0] op, input logic j,
			input logic [3:0] a, input logic [4:0] b, input logic [3:0] d,
			input logic [2:0] c, input logic [11:0] off);
		return {op, j, a, b, d, 1'b0, c, off};
	endfunction

	task automatic emit(input CpuPkg::Word w);
		prog[progLen] = w;
		progLen++;
	endtask

	// Operand A of non-memory ops as the ISA defines it
	function automatic CpuPkg::Word constOrReg(input logic [3:0] a, input CpuPkg::Word r);
		case (a)
			4'd0: return 32'd0;
			4'd1: return 32'hFFFF_FFFF;
			4'd2: return 32'd1;
			4'd3: return 32'hFFFF_FFFC;
			default: return r;
		endcase
	endfunction

	// Instruction-level model returning the step count
	function automatic int runReference();
		CpuPkg::Word regs [16];
		CpuPkg::Word ins;
		CpuPkg::Word opA;
		CpuPkg::Word opB;
		CpuPkg::Word res;
		CpuPkg::Pc pc;
		CpuPkg::MemWordAddr addr;
		logic [2:0] flags;
		int steps;
		int cycle;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		steps = 0;
		// First instruction is valid one cycle after reset release
		cycle = 1;
		while (steps < 5000) begin
			ins = prog[pc[8:1]];
			steps++;
			if (ins[31:30] == CpuPkg::OpMem) begin
				opA = {{27{ins[28]}}, ins[28:25], 1'b0};
			end else begin
				opA = constOrReg(ins[28:25], regs[ins[28:25]]);
			end
			// Operand B constants by priority
			if (!ins[24]) begin
				opB = regs[ins[23:20]];
			end else if (ins[20]) begin
				opB = 32'hFFFF_FFFF;
			end else if (ins[21]) begin
				opB = 32'd1;
			end else if (ins[22]) begin
				opB = {15'd0, pc, 1'b0};
			end else if (ins[23]) begin
				opB = 32'd32;
			end else begin
				opB = '0;
			end
			if (ins[31:30] == CpuPkg::OpMem) begin
				res = opA - opB;
				addr = res[10:2];
				if (ins[29]) begin
					expAddr[expCount] = addr;
					expData[expCount] = regs[ins[19:16]];
					// Access cycle right after the address cycle
					expCycle[expCount] = cycle + 1;
					expCount++;
					refMem[addr] = regs[ins[19:16]];
				end else begin
					regs[ins[19:16]] = refMem[addr];
				end
				pc = pc + 16'd2;
				cycle = cycle + 2;
			end else if (ins[31:30] == CpuPkg::OpShift) begin
				regs[ins[19:16]] = ins[24] ? (opA >> ins[23:20]) : (opA << ins[23:20]);
				pc = pc + 16'd2;
				cycle = cycle + 1;
			end else begin
				res = (ins[31:30] == CpuPkg::OpXan) ? (opA & ~opB) : (opA - opB);
				regs[ins[19:16]] = res;
				// Zero, negative, above zero
				flags = {!res[31] && (res != 0), res[31], res == 0};
				if (ins[29] && ((flags & ins[14:12]) != 3'b000)) begin
					// Branch to itself ends the program
					if (ins[11:0] == 12'd0) begin
						return steps;
					end
					pc = pc + {{4{ins[11]}}, ins[11:0]};
					// Flushed successor takes one cycle
					cycle = cycle + 2;
				end else begin
					pc = pc + 16'd2;
					cycle = cycle + 1;
				end
			end
		end
		return steps;
	endfunction

	task automatic buildProgram();
		logic [3:0] d;
		int c;
		// r4 holds 256 and r5 holds -256 as memory base
		emit(enc(CpuPkg::OpShift, 0, 4'd2, 5'h08, 4'd4, 0, 0));
		emit(enc(CpuPkg::OpSub, 0, 4'd0, 5'd4, 4'd5, 0, 0));
		for (int i = 0; i < 8; i++) begin
			emit(enc(CpuPkg::OpMem, 0, 4'(-8 + 2 * i), 5'd5, 4'(6 + i), 0, 0));
		end
		// Random ALU ops with the last one on the PC operand
		for (int i = 0; i < 13; i++) begin
			d = 4'(6 + randBits(3));
			emit(enc(randBits(1) ? CpuPkg::OpXan : CpuPkg::OpSub, 0, 4'(randBits(4)),
				(i == 12) ? 5'h14 : 5'(randBits(5)), d, 0, 0));
			emit(enc(CpuPkg::OpMem, 1, 4'(randBits(4)), 5'd5, d, 0, 0));
		end
		// Random shifts
		for (int i = 0; i < 6; i++) begin
			d = 4'(6 + randBits(3));
			emit(enc(CpuPkg::OpShift, 0, 4'(4 + randBits(3)), 5'(randBits(5)), d, 0, 0));
			emit(enc(CpuPkg::OpMem, 1, 4'(randBits(4)), 5'd5, d, 0, 0));
		end
		// Load then store round trip
		emit(enc(CpuPkg::OpMem, 0, 4'(randBits(4)), 5'd5, 4'd6, 0, 0));
		emit(enc(CpuPkg::OpMem, 1, 4'(randBits(4)), 5'd5, 4'd6, 0, 0));
		// Each condition bit against zero, negative and positive results
		for (int k = 0; k < 9; k++) begin
			c = 1 << (k / 3);
			emit(enc(CpuPkg::OpSub, 1, (k % 3 == 2) ? 4'd2 : 4'd0,
				(k % 3 == 1) ? 5'h12 : 5'h10, 4'd3, 3'(c), 12'd4));
			emit(enc(CpuPkg::OpSub, 0, 4'd15, 5'h11, 4'd15, 0, 0));
			emit(enc(CpuPkg::OpMem, 1, 4'd0, 5'd5, 4'd15, 0, 0));
		end
		// Counted loop of four passes
		emit(enc(CpuPkg::OpShift, 0, 4'd2, 5'h02, 4'd14, 0, 0));
		emit(enc(CpuPkg::OpSub, 0, 4'd15, 5'h11, 4'd15, 0, 0));
		emit(enc(CpuPkg::OpMem, 1, 4'd1, 5'd5, 4'd15, 0, 0));
		emit(enc(CpuPkg::OpSub, 1, 4'd14, 5'h12, 4'd14, 3'b100, 12'hFFC));
		// Park on a self loop
		emit(enc(CpuPkg::OpSub, 1, 4'd0, 5'h10, 4'd3, 3'b001, 12'd0));
		for (int i = progLen; i < CpuPkg::ImemDepth; i++) begin
			prog[i] = prog[progLen - 1];
		end
	endtask

	// No memory traffic while held in reset
	always @(negedge CLK) begin
		if (!RST_X && MemEn) begin
			$display("MemEn went high during reset or program load");
			otherErrors++;
		end
	end

	// Store comparison against the reference list
	always @(negedge CLK) begin
		if (RST_X) begin
			if (MemEn && prevEn) begin
				$display("MemEn stayed high for two cycles in a row");
				otherErrors++;
			end
			prevEn = MemEn;
			if (MemEn && MemWen) begin
				if (storeCount >= expCount) begin
					$display("Extra store beyond the %0d expected", expCount);
					otherErrors++;
				end else begin
					if (MemAddr != expAddr[storeCount]) begin
						$display("Error MemAddr store %0d got %h expected %h",
							storeCount, MemAddr, expAddr[storeCount]);
						valueErrors++;
					end
					if (MemWdata != expData[storeCount]) begin
						$display("Error MemWdata store %0d got %h expected %h",
							storeCount, MemWdata, expData[storeCount]);
						valueErrors++;
					end
					if (cycleNo != expCycle[storeCount]) begin
						$display("Store %0d came in cycle %0d instead of cycle %0d",
							storeCount, cycleNo, expCycle[storeCount]);
						otherErrors++;
					end
				end
				storeCount++;
			end
			cycleNo++;
		end
	end

	task automatic closeRun();
		$display("Stores %0d of %0d, value errors %0d, other errors %0d",
			storeCount, expCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
	endtask

	// Limit from the reference step count
	initial begin
		wait (refDone);
		#((refSteps * 3 + 50 + progLen + 10) * 10);
		$display("Timed out with %0d of %0d stores seen", storeCount, expCount);
		otherErrors++;
		closeRun();
		$finish;
	end

	initial begin
		CLK = 1'b0;
		RST_X = 1'b0;
		LoadEn = 1'b0;
		LoadAddr = '0;
		LoadData = '0;
		for (int i = 0; i < 512; i++) begin
			mem[i] = randBits(32);
			refMem[i] = mem[i];
		end
		buildProgram();
		refSteps = runReference();
		refDone = 1'b1;
		// Load the program plus two padding words
		for (int i = 0; i < progLen + 2; i++) begin
			@(posedge CLK);
			#1;
			LoadEn = 1'b1;
			LoadAddr = CpuPkg::ImemAddr'(i);
			LoadData = prog[i];
		end
		@(posedge CLK);
		#1;
		LoadEn = 1'b0;
		repeat (2) @(posedge CLK);
		#1;
		RST_X = 1'b1;
		wait (storeCount >= expCount);
		repeat (20) @(posedge CLK);
		// Final memory against the reference copy
		for (int i = 0; i < 512; i++) begin
			if (mem[i] != refMem[i]) begin
				$display("Error mem[%h] got %h expected %h", i, mem[i], refMem[i]);
				valueErrors++;
			end
		end
		closeRun();
		$finish;
	end

endmodule

//--- vlog.f
hw/CpuPkg.sv
hw/RegisterFile.sv
hw/Alu.sv
hw/Shifter.sv
hw/ComputeStage.sv
hw/FetchStage.sv
hw/Processor.sv
tb/ProcessorTb.sv

//--- run.sh
#!/bin/bash
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module ProcessorTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
	exit 0
fi
exit 1
